//--- tb.f
+incdir+verilog
verilog/wbu_pkg.sv
verilog/pending_table.sv
verilog/waw_checker.sv
verilog/wb_arbiter.sv
verilog/wbu_top.sv
bench/wbu_tb.sv

//--- Makefile
# Verilator build for the writeback unit

VERILATOR  ?= verilator
TOP        := wbu_tb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  := --binary --timing --assert -j 0 -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# a $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/wbu_tb.sv
// Writeback unit testbench
// Table of issue and request rows with expected grants, followed by a
// random section checked against a small priority model

`include "wbu_cfg.svh"

module wbu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NSRC = `WBU_NUM_SRC;
    localparam int AW   = `WBU_ADDR_W;
    localparam int DW   = `WBU_DATA_W;
    localparam int CW   = `WBU_CID_W;
    localparam int TW   = `WBU_TS_W;

    // one applied cycle, inputs first, expected outputs after
    typedef struct packed {
        wbu_pkg::dest_t    [1:0]      issue;
        wbu_pkg::wb_req_t  [NSRC-1:0] req;
        logic              [NSRC-1:0] ready;
        wbu_pkg::wb_port_t [1:0]      wb;
        wbu_pkg::commit_t  [1:0]      commit;
        logic                         full;
    } row_t;

    logic                         clk;
    logic                         rst_n;
    wbu_pkg::wb_req_t  [NSRC-1:0] req_i;
    wbu_pkg::dest_t    [1:0]      issue_i;
    logic              [NSRC-1:0] ready_o;
    wbu_pkg::wb_port_t [1:0]      wb_o;
    wbu_pkg::commit_t  [1:0]      commit_o;
    logic                         pending_full_o;

    row_t   rows[$];
    string  names[$];
    row_t   cur;
    string  cur_name;
    bit     row_open;
    integer seed;

    wbu_top DUT (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_val(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %0h actual %0h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic close_row();
        if (row_open) begin
            rows.push_back(cur);
            names.push_back(cur_name);
        end
        row_open = 1'b0;
    endtask

    // closes the row in progress and starts an idle one
    task automatic open_row(input string name, input logic full);
        close_row();
        cur      = '0;
        cur.full = full;
        cur_name = name;
        row_open = 1'b1;
    endtask

    // data and cid follow from source and timestamp, ch < 0 means not granted
    task automatic place_req(input int src, input int addr, input int ts, input int ch);
        cur.req[src].we   = 1'b1;
        cur.req[src].addr = AW'(addr);
        cur.req[src].data = DW'({8'hda, 8'(src), 16'(ts)});
        cur.req[src].cid  = CW'(ts);
        cur.req[src].ts   = TW'(ts);
        if (ch >= 0) begin
            cur.ready[src]       = 1'b1;
            cur.wb[ch]           = {1'b1, cur.req[src].addr, cur.req[src].data};
            cur.commit[ch].valid = 1'b1;
            cur.commit[ch].cid   = cur.req[src].cid;
        end
    endtask

    task automatic place_issue(input int k, input int addr, input int ts);
        cur.issue[k].valid = 1'b1;
        cur.issue[k].addr  = AW'(addr);
        cur.issue[k].ts    = TW'(ts);
    endtask

    // drive on the rising edge, sample just before the next one
    task automatic apply_and_check(input row_t r, input string name);
        @(posedge clk);
        req_i   <= r.req;
        issue_i <= r.issue;
        #18;
        check_val({name, " ready"}, 64'(r.ready), 64'(ready_o));
        for (int c = 0; c < 2; c++) begin
            check_val($sformatf("%s wb%0d", name, c), 64'(r.wb[c]), 64'(wb_o[c]));
            check_val($sformatf("%s commit%0d", name, c), 64'(r.commit[c]),
                      64'(commit_o[c]));
        end
        check_val({name, " full"}, 64'(r.full), 64'(pending_full_o));
    endtask

    task automatic wait_not_full(input int max_cycles);
        int n;
        n = 0;
        while (pending_full_o) begin
            if (n == max_cycles) begin
                $display("Timeout waiting for the pending table to leave full");
                $display("Finished with errors");
                $fatal(1, "timeout");
            end else begin
                n++;
                @(posedge clk);
            end
        end
    endtask

    // ==========================================================
    // directed rows
    // ==========================================================
    task automatic build_rows();
        open_row("idle", 1'b0);
        // source 5 loses to sources 1 and 3 and waits a row
        open_row("priority", 1'b0);
        place_req(1, 1, 1, 0);
        place_req(3, 2, 2, 1);
        place_req(5, 3, 3, -1);
        open_row("priority held", 1'b0);
        place_req(5, 3, 3, 0);
        // adder 1 owns the older write to r7
        open_row("same cycle waw", 1'b0);
        place_req(0, 7, 25, -1);
        place_req(5, 7, 20, 0);
        open_row("waw younger", 1'b0);
        place_req(0, 7, 25, 0);
        open_row("issue r5", 1'b0);
        place_issue(0, 5, 10);
        for (int k = 0; k < 2; k++) begin
            open_row("pending hold", 1'b0);
            place_req(2, 5, 12, -1);
        end
        open_row("pending release", 1'b0);
        place_req(2, 5, 12, -1);
        place_req(4, 5, 10, 0);
        open_row("after release", 1'b0);
        place_req(2, 5, 12, 0);
        // seven tracked registers r10 to r16
        for (int k = 0; k < 4; k++) begin
            open_row("fill", 1'b0);
            place_issue(0, 10 + 2 * k, 100 + 2 * k);
            if (k < 3) begin
                place_issue(1, 11 + 2 * k, 101 + 2 * k);
            end
        end
        open_row("full issue dropped", 1'b1);
        place_issue(0, 20, 200);
        open_row("full req r20", 1'b1);
        place_req(1, 20, 201, 0);
        open_row("full drain", 1'b1);
        place_req(3, 10, 100, 0);
        for (int k = 0; k < 3; k++) begin
            open_row("drain", 1'b0);
            place_req(0, 11 + 2 * k, 101 + 2 * k, 0);
            place_req(1, 12 + 2 * k, 102 + 2 * k, 1);
        end
        open_row("empty", 1'b0);
        close_row();
    endtask

    // ==========================================================
    // random requests, distinct registers, empty table
    // ==========================================================
    task automatic run_random(input int iters);
        row_t            rr;
        logic [NSRC-1:0] active;
        int              ch;
        int              r;
        rr     = '0;
        active = '0;
        for (int n = 0; n < iters; n++) begin
            for (int s = 0; s < NSRC; s++) begin
                r = $random(seed);
                if (!active[s] && r[0]) begin
                    active[s]       = 1'b1;
                    rr.req[s].we    = 1'b1;
                    // each source owns its own block of registers
                    rr.req[s].addr  = AW'(1 + 5 * s + int'(r[2:1]));
                    rr.req[s].data  = DW'($random(seed));
                    rr.req[s].cid   = CW'(r[6:3]);
                    rr.req[s].ts    = TW'(1000 + n);
                end
            end
            rr.ready  = '0;
            rr.wb     = '0;
            rr.commit = '0;
            ch        = 0;
            for (int s = 0; s < NSRC; s++) begin
                if (active[s] && ch < 2) begin
                    rr.ready[s]   = 1'b1;
                    rr.wb[ch]     = {1'b1, rr.req[s].addr, rr.req[s].data};
                    rr.commit[ch] = {1'b1, rr.req[s].cid};
                    ch++;
                end
            end
            apply_and_check(rr, $sformatf("random %0d", n));
            // losers keep their request for the next cycle
            active = active & ~rr.ready;
            for (int s = 0; s < NSRC; s++) begin
                if (rr.ready[s]) begin
                    rr.req[s] = '0;
                end
            end
        end
    endtask

    initial begin
        seed     = 32'hed45;
        row_open = 1'b0;
        rst_n    = 1'b0;
        req_i    = '0;
        issue_i  = '0;
        build_rows();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        foreach (rows[i]) begin
            apply_and_check(rows[i], names[i]);
        end
        wait_not_full(10);
        run_random(40);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- verilog/wbu_top.sv
// Writeback unit top
// Pending table feeds the WAW checker, whose eligible set goes to the
// arbiter. Granted writes release their table entries at the same edge.

`include "wbu_cfg.svh"

module wbu_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  wbu_pkg::wb_req_t  [`WBU_NUM_SRC-1:0] req_i,
    input  wbu_pkg::dest_t    [1:0]              issue_i,
    output logic              [`WBU_NUM_SRC-1:0] ready_o,
    output wbu_pkg::wb_port_t [1:0]              wb_o,
    output wbu_pkg::commit_t  [1:0]              commit_o,
    output logic                                 pending_full_o
);

    wbu_pkg::dest_t [`WBU_TABLE_DEPTH-1:0] entries;
    wbu_pkg::dest_t [1:0]                  release_dest;
    logic           [`WBU_NUM_SRC-1:0]     eligible;

    pending_table u_pending_table (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_i        (issue_i),
        .release_i      (release_dest),
        .entries_o      (entries),
        .pending_full_o (pending_full_o)
    );

    waw_checker u_waw_checker (
        .req_i      (req_i),
        .entries_i  (entries),
        .eligible_o (eligible)
    );

    wb_arbiter u_wb_arbiter (
        .req_i      (req_i),
        .eligible_i (eligible),
        .ready_o    (ready_o),
        .wb_o       (wb_o),
        .commit_o   (commit_o),
        .release_o  (release_dest)
    );

endmodule

//--- verilog/wb_arbiter.sv
// Writeback arbiter
// Grants up to two eligible sources in fixed priority order onto the
// two register file ports and reports commits and table releases.

`include "wbu_cfg.svh"

module wb_arbiter (
    input  wbu_pkg::wb_req_t  [`WBU_NUM_SRC-1:0] req_i,
    input  logic              [`WBU_NUM_SRC-1:0] eligible_i,
    output logic              [`WBU_NUM_SRC-1:0] ready_o,
    output wbu_pkg::wb_port_t [1:0]              wb_o,
    output wbu_pkg::commit_t  [1:0]              commit_o,
    output wbu_pkg::dest_t    [1:0]              release_o
);

    localparam int NUM_SRC = `WBU_NUM_SRC;
    localparam int IDX_W   = $clog2(NUM_SRC);

    logic [NUM_SRC-1:0] pool;
    logic [IDX_W-1:0]   grant_idx [2];
    logic [1:0]         grant_vld;

    // ==========================================================
    // channel selection
    // ==========================================================
    always_comb begin
        pool      = eligible_i;
        grant_vld = '0;
        for (int c = 0; c < 2; c++) begin
            grant_idx[c] = '0;
            // downward scan leaves the lowest index
            for (int s = NUM_SRC - 1; s >= 0; s--) begin
                if (pool[s]) begin
                    grant_vld[c] = 1'b1;
                    grant_idx[c] = IDX_W'(s);
                end
            end
            if (grant_vld[c]) begin
                pool[grant_idx[c]] = 1'b0;
            end
        end
    end

    // ==========================================================
    // port, commit and release muxing
    // ==========================================================
    always_comb begin
        ready_o = '0;
        for (int c = 0; c < 2; c++) begin
            wb_o[c]      = '0;
            commit_o[c]  = '0;
            release_o[c] = '0;
            if (grant_vld[c]) begin
                ready_o[grant_idx[c]] = 1'b1;
                wb_o[c].we         = req_i[grant_idx[c]].we;
                wb_o[c].addr       = req_i[grant_idx[c]].addr;
                wb_o[c].data       = req_i[grant_idx[c]].data;
                commit_o[c].valid  = 1'b1;
                commit_o[c].cid    = req_i[grant_idx[c]].cid;
                release_o[c].valid = 1'b1;
                release_o[c].addr  = req_i[grant_idx[c]].addr;
                release_o[c].ts    = req_i[grant_idx[c]].ts;
            end
        end
    end

    // every valid channel raises a ready bit of its own
    always_comb begin
        assert final ($countones(ready_o) == $countones(grant_vld));
    end

endmodule

//--- verilog/waw_checker.sv
// WAW checker
// Holds back any request whose register still has an older write
// outstanding, either in the pending table or from another source now.

`include "wbu_cfg.svh"

module waw_checker (
    input  wbu_pkg::wb_req_t [`WBU_NUM_SRC-1:0]     req_i,
    input  wbu_pkg::dest_t   [`WBU_TABLE_DEPTH-1:0] entries_i,
    output logic             [`WBU_NUM_SRC-1:0]     eligible_o
);

    localparam int NUM_SRC = `WBU_NUM_SRC;
    localparam int DEPTH   = `WBU_TABLE_DEPTH;

    logic [NUM_SRC-1:0] req_we;
    logic [NUM_SRC-1:0] table_block;
    logic [NUM_SRC-1:0] peer_block;
    logic [NUM_SRC-1:0] waw_clash;

    // ==========================================================
    // older write still tracked in the table
    // ==========================================================
    always_comb begin
        table_block = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            req_we[s] = req_i[s].we;
            for (int e = 0; e < DEPTH; e++) begin
                // equal timestamp is this same instruction
                if (entries_i[e].valid && (entries_i[e].addr == req_i[s].addr)
                    && (entries_i[e].ts < req_i[s].ts)) begin
                    table_block[s] = 1'b1;
                end
            end
        end
    end

    // ==========================================================
    // older write arriving in the same cycle
    // ==========================================================
    always_comb begin
        peer_block = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            for (int j = 0; j < NUM_SRC; j++) begin
                if ((j != s) && req_i[j].we && (req_i[j].addr == req_i[s].addr)
                    && (req_i[j].ts < req_i[s].ts)) begin
                    peer_block[s] = 1'b1;
                end
            end
        end
    end

    assign eligible_o = req_we & ~(table_block | peer_block);

    // eligible writes to one register all belong to one instruction
    always_comb begin
        waw_clash = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            for (int j = 0; j < NUM_SRC; j++) begin
                if (eligible_o[s] && eligible_o[j] && (req_i[j].addr == req_i[s].addr)
                    && (req_i[j].ts != req_i[s].ts)) begin
                    waw_clash[s] = 1'b1;
                end
            end
        end
        assert final (waw_clash == '0);
    end

endmodule

//--- verilog/pending_table.sv
// Pending destination table
// Tracks register and timestamp of every issued instruction until its
// writeback is granted. Two issues and two releases per cycle.

`include "wbu_cfg.svh"

module pending_table (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  wbu_pkg::dest_t [1:0]                  issue_i,
    input  wbu_pkg::dest_t [1:0]                  release_i,
    output wbu_pkg::dest_t [`WBU_TABLE_DEPTH-1:0] entries_o,
    output logic                                  pending_full_o
);

    localparam int DEPTH = `WBU_TABLE_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DEPTH-1:0]       valid_q;
    logic [`WBU_ADDR_W-1:0] addr_q [DEPTH];
    logic [`WBU_TS_W-1:0]   ts_q [DEPTH];
    logic [CNT_W-1:0]       used_cnt;
    logic [DEPTH-1:0]       free_mask;
    logic [DEPTH-1:0]       free_first;
    logic [DEPTH-1:0]       free_second;
    logic [1:0]             issue_ok;
    logic [DEPTH-1:0]       alloc [2];
    logic [DEPTH-1:0]       rel_match [2];
    logic [DEPTH-1:0]       rel_hit [2];

    // ==========================================================
    // occupancy and free slot search
    // ==========================================================
    always_comb begin
        used_cnt = '0;
        for (int i = 0; i < DEPTH; i++) begin
            used_cnt = used_cnt + CNT_W'(valid_q[i]);
        end
    end

    // full once fewer than two slots remain
    assign pending_full_o = (used_cnt > CNT_W'(DEPTH - 2));

    assign free_mask   = ~valid_q;
    // lowest set bit isolates the first free slot
    assign free_first  = free_mask & (~free_mask + DEPTH'(1));
    assign free_second = (free_mask & ~free_first) & (~(free_mask & ~free_first) + DEPTH'(1));

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            issue_ok[k] = issue_i[k].valid && (issue_i[k].addr != '0) && !pending_full_o;
        end
        alloc[0] = issue_ok[0] ? free_first : '0;
        // second issue slides down when the first one is absent
        alloc[1] = issue_ok[1] ? (issue_ok[0] ? free_second : free_first) : '0;
    end

    // ==========================================================
    // release lookup
    // ==========================================================
    always_comb begin
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < DEPTH; i++) begin
                rel_match[r][i] = release_i[r].valid && valid_q[i]
                                  && (addr_q[i] == release_i[r].addr)
                                  && (ts_q[i] == release_i[r].ts);
            end
            // only the first matching slot is cleared
            rel_hit[r] = rel_match[r] & (~rel_match[r] + DEPTH'(1));
        end
    end

    // ==========================================================
    // slot state
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q & ~(rel_hit[0] | rel_hit[1])) | alloc[0] | alloc[1];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (alloc[0][i]) begin
                addr_q[i] <= issue_i[0].addr;
                ts_q[i]   <= issue_i[0].ts;
            end else if (alloc[1][i]) begin
                addr_q[i] <= issue_i[1].addr;
                ts_q[i]   <= issue_i[1].ts;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            entries_o[i].valid = valid_q[i];
            entries_o[i].addr  = addr_q[i];
            entries_o[i].ts    = ts_q[i];
        end
    end

    // occupancy never grows across an edge that starts full
    assert property (@(posedge clk) disable iff (!rst_n)
        pending_full_o |=> (used_cnt <= $past(used_cnt)));

    // arbiter never sends two releases for one tracked instruction
    assert property (@(posedge clk) disable iff (!rst_n)
        (rel_hit[0] & rel_hit[1]) == '0);

endmodule

//--- verilog/wbu_pkg.sv
// Writeback unit types
// Request, tracked destination, write port and commit report bundles

`include "wbu_cfg.svh"

package wbu_pkg;

    // one execution source asking to write a register
    typedef struct packed {
        logic                   we;
        logic [`WBU_ADDR_W-1:0] addr;
        logic [`WBU_DATA_W-1:0] data;
        logic [`WBU_CID_W-1:0]  cid;
        logic [`WBU_TS_W-1:0]   ts;
    } wb_req_t;

    // destination of an issued instruction
    typedef struct packed {
        logic                   valid;
        logic [`WBU_ADDR_W-1:0] addr;
        logic [`WBU_TS_W-1:0]   ts;
    } dest_t;

    // register file write port
    typedef struct packed {
        logic                   we;
        logic [`WBU_ADDR_W-1:0] addr;
        logic [`WBU_DATA_W-1:0] data;
    } wb_port_t;

    typedef struct packed {
        logic                  valid;
        logic [`WBU_CID_W-1:0] cid;
    } commit_t;

endpackage

//--- verilog/wbu_cfg.svh
// Writeback unit configuration
// Widths, source count and pending table depth shared by all blocks

`ifndef WBU_CFG_SVH
`define WBU_CFG_SVH

`define WBU_DATA_W       32
`define WBU_ADDR_W       5
`define WBU_TS_W         32
`define WBU_CID_W        4
`define WBU_NUM_SRC      6
`define WBU_TABLE_DEPTH  8

// source index is also priority, 0 wins
//   0 load/store 2    1 load/store 1
//   2 multiplier 2    3 multiplier 1
//   4 adder 2         5 adder 1

`endif
